/* fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

`define MEM_WORD_BITS 64
`define LANE_BITS 16
`define LANES_PER_WORD 4 // MEM_WORD_BITS / LANE_BITS.
`define MEM_DEPTH 16
`define MEM_ADDR_BITS 4
`define MEM_READ_LATENCY 2 // Cycles from an accepted read to its response pulse.

`define NUM_STREAMS 2

// First word fetched by each stream.
`define STREAM0_BASE 0
`define STREAM1_BASE 8

`endif

/* lane_fetch.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module lane_fetch #(
  parameter mem_pkg::mem_addr_t BASE_ADDR = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      en,
  input  logic                      available_read,
  output logic                      want,
  output mem_pkg::mem_req_t         req,
  input  mem_pkg::mem_rsp_t         rsp,
  input  logic                      pop_data,
  output stream_pkg::stream_out_t   out
);
  import mem_pkg::*;
  import stream_pkg::*;

  localparam lane_idx_t LAST_LANE = lane_idx_t'(`LANES_PER_WORD - 1);

  typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_FULL} rd_state_t;
  typedef enum logic {SV_EMPTY, SV_SERVE} sv_state_t;

  rd_state_t rd_state;
  sv_state_t sv_state;
  mem_addr_t addr;
  mem_word_u buffer;
  mem_word_u serve_word;
  lane_idx_t lane_idx;
  logic      buffer_read;
  logic      buffer_ready;
  logic      available_pop;
  logic      pop_accept;
  logic      load_serve;

  assign want = (rd_state == RD_IDLE) && en;

  // Read side. A grant is always taken up, even if en has just dropped,
  // because the arbiter waits for the request.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
      addr     <= BASE_ADDR;
      req      <= '0;
    end else begin
      req.valid <= 1'b0;
      case (rd_state)
        RD_IDLE: begin
          if (available_read) begin
            req.valid <= 1'b1;
            req.addr  <= addr;
            addr      <= (int'(addr) == `MEM_DEPTH - 1) ? '0 : addr + 1'b1;
            rd_state  <= RD_WAIT;
          end
        end
        RD_WAIT: if (rsp.valid) rd_state <= RD_FULL;
        RD_FULL: if (buffer_read) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_state == RD_WAIT && rsp.valid) buffer <= rsp.data;
  end

  // The release strobe lags the load by a cycle, so ignore the buffer meanwhile.
  assign buffer_ready  = (rd_state == RD_FULL) && !buffer_read;
  assign available_pop = (sv_state == SV_SERVE);
  assign pop_accept    = pop_data && available_pop;
  assign load_serve    = buffer_ready &&
                         (!available_pop || (pop_accept && lane_idx == LAST_LANE));

  always_ff @(posedge clk) begin
    if (rst) begin
      sv_state    <= SV_EMPTY;
      lane_idx    <= '0;
      buffer_read <= 1'b0;
    end else begin
      buffer_read <= load_serve;
      if (load_serve) begin
        lane_idx <= '0;
        sv_state <= SV_SERVE;
      end else if (pop_accept) begin
        lane_idx <= lane_idx + 1'b1; // Wraps to lane 0 after the last lane.
        if (lane_idx == LAST_LANE) sv_state <= SV_EMPTY;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_serve) serve_word <= buffer;
  end

  assign out.available = available_pop;
  assign out.lane      = serve_word.lanes[lane_idx];

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module mem_arbiter (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`NUM_STREAMS-1:0]               want,
  input  mem_pkg::mem_req_t [`NUM_STREAMS-1:0]  unit_req,
  output logic [`NUM_STREAMS-1:0]               available_read,
  output mem_pkg::mem_rsp_t [`NUM_STREAMS-1:0]  unit_rsp,
  output mem_pkg::mem_req_t                     mem_req,
  input  mem_pkg::mem_rsp_t                     mem_rsp
);

  localparam int N        = `NUM_STREAMS;
  localparam int IDX_BITS = ($clog2(N) > 0) ? $clog2(N) : 1;

  typedef enum logic [1:0] {ARB_IDLE, ARB_GRANTED, ARB_BUSY} arb_state_t;

  arb_state_t          state;
  logic [IDX_BITS-1:0] ptr; // Stream with the highest priority for the next grant.
  logic [IDX_BITS-1:0] owner;
  logic [IDX_BITS-1:0] grant_idx;
  logic                grant_found;

  // Search the wanting units starting from the pointer.
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = ptr;
    for (int i = 0; i < N; i++) begin
      if (!grant_found && want[(int'(ptr) + i) % N]) begin
        grant_found = 1'b1;
        grant_idx   = IDX_BITS'((int'(ptr) + i) % N);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= ARB_IDLE;
      ptr            <= '0;
      owner          <= '0;
      available_read <= '0;
    end else begin
      available_read <= '0; // A grant is a one-cycle strobe.
      case (state)
        ARB_IDLE: begin
          if (grant_found) begin
            available_read[grant_idx] <= 1'b1;
            owner <= grant_idx;
            state <= ARB_GRANTED;
          end
        end
        ARB_GRANTED: begin
          if (unit_req[owner].valid) state <= ARB_BUSY;
        end
        ARB_BUSY: begin
          if (mem_rsp.valid) begin
            ptr   <= (int'(owner) == N - 1) ? '0 : owner + 1'b1;
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // Only the granted unit's request reaches the memory.
  assign mem_req.valid = (state == ARB_GRANTED) && unit_req[owner].valid;
  assign mem_req.addr  = unit_req[owner].addr;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      unit_rsp[i].data  = mem_rsp.data;
      unit_rsp[i].valid = mem_rsp.valid && (state == ARB_BUSY) && (int'(owner) == i);
    end
  end

endmodule

/* mem_pkg.sv */
`include "fetch_params.svh"

package mem_pkg;

  typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;

  // One memory word. The memory stores it raw; the fetch units pick lanes out of it.
  typedef union packed {
    logic [`MEM_WORD_BITS-1:0] raw;
    stream_pkg::lane_t [`LANES_PER_WORD-1:0] lanes; // Lane 0 sits in the low bits.
  } mem_word_u;

  typedef struct packed {
    logic valid;
    mem_addr_t addr;
  } mem_req_t;

  typedef struct packed {
    logic valid; // Single-cycle pulse.
    mem_word_u data;
  } mem_rsp_t;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f stream_fetch_top.f \
  --top-module stream_fetch_top_tb -o sim_stream_fetch_top

# The simulation exits with an error status on failure; the log decides the result.
./obj_dir/sim_stream_fetch_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without a result."; exit 1; }

/* stream_fetch_top.f */
+incdir+.
stream_pkg.sv
mem_pkg.sv
wide_mem.sv
mem_arbiter.sv
lane_fetch.sv
stream_fetch_top.sv
stream_fetch_top_props.sv
stream_fetch_top_tb.sv

/* stream_fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module stream_fetch_top (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    wr_en,
  input  mem_pkg::mem_addr_t                      wr_addr,
  input  mem_pkg::mem_word_u                      wr_data,
  input  logic [`NUM_STREAMS-1:0]                 en,
  input  logic [`NUM_STREAMS-1:0]                 pop,
  output stream_pkg::stream_out_t [`NUM_STREAMS-1:0] stream_out
);
  import mem_pkg::*;

  logic [`NUM_STREAMS-1:0]     want;
  logic [`NUM_STREAMS-1:0]     available_read;
  mem_req_t [`NUM_STREAMS-1:0] unit_req;
  mem_rsp_t [`NUM_STREAMS-1:0] unit_rsp;
  mem_req_t                    mem_req;
  mem_rsp_t                    mem_rsp;

  wide_mem mem_inst (
    .clk, .rst, .wr_en, .wr_addr, .wr_data,
    .req (mem_req),
    .rsp (mem_rsp)
  );

  mem_arbiter arb_inst (
    .clk, .rst, .want, .unit_req, .available_read, .unit_rsp, .mem_req, .mem_rsp
  );

  lane_fetch #(.BASE_ADDR(mem_addr_t'(`STREAM0_BASE))) fetch0_inst (
    .clk, .rst,
    .en (en[0]), .available_read (available_read[0]), .want (want[0]),
    .req (unit_req[0]), .rsp (unit_rsp[0]), .pop_data (pop[0]), .out (stream_out[0])
  );

  lane_fetch #(.BASE_ADDR(mem_addr_t'(`STREAM1_BASE))) fetch1_inst (
    .clk, .rst,
    .en (en[1]), .available_read (available_read[1]), .want (want[1]),
    .req (unit_req[1]), .rsp (unit_rsp[1]), .pop_data (pop[1]), .out (stream_out[1])
  );

endmodule

/* stream_fetch_top_props.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module stream_fetch_top_props (
  input logic                                  clk,
  input logic                                  rst,
  input logic [`NUM_STREAMS-1:0]               available_read,
  input mem_pkg::mem_req_t [`NUM_STREAMS-1:0]  unit_req,
  input mem_pkg::mem_req_t                     mem_req,
  input mem_pkg::mem_rsp_t                     mem_rsp
);

  localparam int LAT = `MEM_READ_LATENCY;

  logic outstanding; // A read sits in the memory pipeline.

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
    end else if (mem_req.valid) begin
      outstanding <= 1'b1;
    end else if (mem_rsp.valid) begin
      outstanding <= 1'b0;
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(available_read))
    else $error("More than one unit holds available_read.");

  for (genvar i = 0; i < `NUM_STREAMS; i++) begin : g_unit
    a_req_after_grant: assert property (@(posedge clk) disable iff (rst)
      unit_req[i].valid |-> $past(available_read[i]))
      else $error("Unit %0d sent a request without a grant the cycle before.", i);
  end

  a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
    !(outstanding && mem_req.valid))
    else $error("Memory request issued while a read was outstanding.");

  // Both directions together make the latency exact.
  a_rsp_follows_req: assert property (@(posedge clk) disable iff (rst)
    $past(mem_req.valid, LAT) |-> mem_rsp.valid)
    else $error("Memory response missing after the read latency.");

  a_rsp_has_req: assert property (@(posedge clk) disable iff (rst)
    mem_rsp.valid |-> $past(mem_req.valid, LAT))
    else $error("Memory response without a request at the read latency.");

endmodule

bind stream_fetch_top stream_fetch_top_props props_inst (
  .clk (clk), .rst (rst), .available_read (available_read), .unit_req (unit_req),
  .mem_req (mem_req), .mem_rsp (mem_rsp)
);

/* stream_fetch_top_tb.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module stream_fetch_top_tb;
  import mem_pkg::*;
  import stream_pkg::*;

  localparam int N            = `NUM_STREAMS;
  localparam int LANES        = `LANES_PER_WORD;
  localparam int RESET_CYCLES = 8;
  localparam int MODE_IDLE    = 0;
  localparam int MODE_ALWAYS  = 1;
  localparam int MODE_RANDOM  = 2;
  localparam int SINGLE_POPS  = 80; // Twenty words, so stream 0 wraps past the last address.
  localparam int RANDOM_POPS  = 200;
  localparam int STALL_ROUNDS = 6;
  localparam int MAX_STALL    = 31;
  localparam int RESUME_POPS  = 40;
  localparam int QUIET_CYCLES = 16;
  localparam int PLANNED_POPS = SINGLE_POPS + N * RANDOM_POPS + STALL_ROUNDS * (MAX_STALL + 1)
                                + N * (RESUME_POPS + 3 * LANES);
  localparam int WORD_CYCLES  = 12; // Worst case for one word with both streams competing.
  localparam int CYCLE_LIMIT  = 4 * (PLANNED_POPS * WORD_CYCLES + RESET_CYCLES + `MEM_DEPTH);

  logic                    clk;
  logic                    rst;
  logic                    wr_en;
  mem_addr_t               wr_addr;
  mem_word_u               wr_data;
  logic [N-1:0]            en;
  logic [N-1:0]            pop;
  stream_out_t [N-1:0]     stream_out;

  mem_word_u model_mem [`MEM_DEPTH];
  mem_addr_t next_addr [N];
  lane_idx_t next_lane [N];
  int        pop_count [N];
  int        pop_mode [N];
  logic      expect_idle [N];
  int        cycle_count = 0;

  stream_fetch_top stream_fetch_top_inst (
    .clk, .rst, .wr_en, .wr_addr, .wr_data, .en, .pop, .stream_out
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) stop_run("Timeout: the run did not finish in time.");
  end

  task automatic check_lane(input lane_t got, input lane_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t: %s lane is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_available(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH at %0t: %s available is %b, expected %b",
                         $time, what, got, exp));
    end
  endtask

  // One accepted pop moves the model to the next lane, and to the next word after the last.
  task automatic advance_model(input int s);
    pop_count[s]++;
    if (next_lane[s] == lane_idx_t'(LANES - 1)) begin
      next_lane[s] = '0;
      next_addr[s] = mem_addr_t'((int'(next_addr[s]) + 1) % `MEM_DEPTH);
    end else begin
      next_lane[s] = next_lane[s] + 1'b1;
    end
  endtask

  // Outputs are stable at the falling edge, so they are checked there and pops driven there.
  task automatic run_cycle();
    logic do_pop;
    @(negedge clk);
    for (int s = 0; s < N; s++) begin
      if (expect_idle[s]) check_available(stream_out[s].available, 1'b0, "idle stream");
      if (stream_out[s].available) begin
        check_lane(stream_out[s].lane, model_mem[next_addr[s]].lanes[next_lane[s]],
                   $sformatf("stream %0d", s));
      end
      case (pop_mode[s])
        MODE_ALWAYS: do_pop = 1'b1;
        MODE_RANDOM: do_pop = ($urandom % 2) == 1;
        default:     do_pop = 1'b0;
      endcase
      pop[s] = do_pop;
      if (do_pop && stream_out[s].available) advance_model(s);
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      for (int s = 0; s < N; s++) check_available(stream_out[s].available, 1'b0, "reset");
    end
    rst = 1'b0;
    @(negedge clk);
    for (int s = 0; s < N; s++) check_available(stream_out[s].available, 1'b0, "post-reset");
  endtask

  task automatic fill_memory();
    mem_word_u word;
    for (int a = 0; a < `MEM_DEPTH; a++) begin
      word.raw     = {$urandom, $urandom};
      model_mem[a] = word;
      @(negedge clk);
      wr_en   = 1'b1;
      wr_addr = mem_addr_t'(a);
      wr_data = word;
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic hold_stream(input int stalled);
    int    other;
    int    len;
    int    start;
    logic  held_valid;
    other      = (stalled + 1) % N;
    len        = 12 + ($urandom % (MAX_STALL - 11));
    start      = pop_count[other];
    held_valid = 1'b0;
    pop_mode[stalled] = MODE_IDLE;
    pop_mode[other]   = MODE_ALWAYS;
    repeat (len) begin
      run_cycle();
      // A shown lane that is not popped must stay on show.
      if (held_valid) check_available(stream_out[stalled].available, 1'b1, "held stream");
      held_valid = stream_out[stalled].available;
    end
    if (pop_count[other] == start) begin
      stop_run($sformatf("Stream %0d delivered nothing while stream %0d was held.",
                         other, stalled));
    end
  endtask

  task automatic drop_and_resume(input int s);
    int limit;
    int start;
    int quiet;
    en[s] = 1'b0; // Driven at the same falling edge as the last pops.
    limit = (LANES - int'(next_lane[s])) + 2 * LANES;
    start = pop_count[s];
    quiet = 0;
    pop_mode[s]           = MODE_ALWAYS;
    pop_mode[(s + 1) % N] = MODE_RANDOM;
    while (quiet < QUIET_CYCLES) begin
      run_cycle();
      quiet = stream_out[s].available ? 0 : quiet + 1;
    end
    if (pop_count[s] - start > limit) begin
      stop_run($sformatf("Stream %0d kept delivering lanes after en was dropped.", s));
    end
    expect_idle[s] = 1'b1;
    repeat (20) run_cycle();
    expect_idle[s] = 1'b0;
    en[s]          = 1'b1;
    pop_mode[s]    = MODE_RANDOM;
    start          = pop_count[s];
    while (pop_count[s] - start < RESUME_POPS) run_cycle();
  endtask

  initial begin
    int start0;
    int start1;
    void'($urandom(9));
    rst     = 1'b1;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    en      = '0;
    pop     = '0;
    next_addr[0] = mem_addr_t'(`STREAM0_BASE);
    next_addr[1] = mem_addr_t'(`STREAM1_BASE);
    for (int s = 0; s < N; s++) begin
      next_lane[s]   = '0;
      pop_count[s]   = 0;
      pop_mode[s]    = MODE_IDLE;
      expect_idle[s] = 1'b1;
    end
    apply_reset();
    fill_memory();

    // One stream alone, popped every cycle.
    en[0]          = 1'b1;
    expect_idle[0] = 1'b0;
    pop_mode[0]    = MODE_ALWAYS;
    while (pop_count[0] < SINGLE_POPS) run_cycle();

    // Both streams with random pops.
    en             = '1;
    expect_idle[1] = 1'b0;
    pop_mode[0]    = MODE_RANDOM;
    pop_mode[1]    = MODE_RANDOM;
    start0         = pop_count[0];
    start1         = pop_count[1];
    while (pop_count[0] - start0 < RANDOM_POPS || pop_count[1] - start1 < RANDOM_POPS) begin
      run_cycle();
    end

    repeat (STALL_ROUNDS) hold_stream(int'($urandom % N));
    for (int s = 0; s < N; s++) drop_and_resume(s);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* stream_pkg.sv */
`include "fetch_params.svh"

package stream_pkg;

  typedef logic [`LANE_BITS-1:0] lane_t;

  typedef logic [$clog2(`LANES_PER_WORD)-1:0] lane_idx_t;

  // What the consumer sees for one stream.
  typedef struct packed {
    logic available;
    lane_t lane;
  } stream_out_t;

endpackage

/* wide_mem.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module wide_mem (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en,
  input  mem_pkg::mem_addr_t  wr_addr,
  input  mem_pkg::mem_word_u  wr_data,
  input  mem_pkg::mem_req_t   req,
  output mem_pkg::mem_rsp_t   rsp
);
  import mem_pkg::*;

  localparam int LAT = `MEM_READ_LATENCY;

  logic [`MEM_WORD_BITS-1:0] mem_array [`MEM_DEPTH];
  logic [LAT-1:0]            valid_pipe;
  mem_word_u                 data_pipe [LAT];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_array[wr_addr] <= wr_data.raw;
    end
  end

  // Stage 0 holds the word read in the request cycle; the last stage is the response.
  always_ff @(posedge clk) begin
    data_pipe[0].raw <= mem_array[req.addr];
    for (int i = 1; i < LAT; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[LAT-2:0], req.valid};
    end
  end

  assign rsp.valid = valid_pipe[LAT-1];
  assign rsp.data  = data_pipe[LAT-1];

endmodule
